//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing -j 0
LINT_TOP  = trace_debugger
TOP       = tb_trace_debugger
FILELIST  = list.f
LOG       = sim.log
PASS_MSG  = No errors

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/trace_debugger.sv
// risc-v instruction trace encoder, top level
// samples the retirement port into nc/tc/lc stages and emits trace packets

module trace_debugger import trdb_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         inst_valid_i,
    input  logic         iretired_i,
    input  logic         exception_i,
    input  logic         interrupt_i,
    input  priv_lvl_e    priv_lvl_i,
    input  cause_t       ucause_i,
    input  cause_t       scause_i,
    input  cause_t       mcause_i,
    input  addr_t        utval_i,
    input  addr_t        stval_i,
    input  addr_t        mtval_i,
    input  inst_t        inst_data_i,
    input  addr_t        pc_i,
    output logic         packet_valid_o,
    output packet_type_e packet_type_o,
    output length_t      packet_length_o,
    output payload_t     packet_payload_o
);

    cause_t        cause;
    addr_t         tval;

    // next cycle stage
    logic          nc_valid, nc_iretired, nc_exception, nc_interrupt;
    cause_t        nc_cause;
    addr_t         nc_tval, nc_iaddr;
    priv_lvl_e     nc_priv;
    inst_t         nc_inst;
    logic          nc_branch, nc_updiscon;

    // this cycle stage
    logic          tc_valid, tc_iretired, tc_exception, tc_interrupt;
    cause_t        tc_cause;
    addr_t         tc_tval, tc_iaddr;
    priv_lvl_e     tc_priv;
    logic          tc_branch, tc_updiscon, tc_taken;

    // last cycle stage
    logic          lc_valid, lc_exception, lc_interrupt, lc_updiscon;
    cause_t        lc_cause;
    addr_t         lc_tval;

    logic          trace_active, qualified_seen;
    logic          tc_qualified, tc_first_qualified;
    branch_map_t   branch_map;
    branch_count_t branch_count;
    logic          map_full, map_flush, resync_req, resync_rst;
    packet_type_e  tc_packet_type;

    // trap registers of the current privilege level
    always_comb begin
        case (priv_lvl_i)
            M: begin
                cause = mcause_i;
                tval  = mtval_i;
            end
            S: begin
                cause = scause_i;
                tval  = stval_i;
            end
            default: begin
                cause = ucause_i;
                tval  = utval_i;
            end
        endcase
    end

    // control bits of the three stages
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            {nc_valid, nc_iretired, nc_exception, nc_interrupt} <= '0;
            {tc_valid, tc_iretired, tc_exception, tc_interrupt} <= '0;
            {tc_branch, tc_updiscon} <= '0;
            {lc_valid, lc_exception, lc_interrupt, lc_updiscon} <= '0;
            trace_active   <= 1'b0;
            qualified_seen <= 1'b0;
        end else begin
            nc_valid     <= inst_valid_i;
            nc_iretired  <= iretired_i;
            nc_exception <= exception_i;
            nc_interrupt <= interrupt_i;
            tc_valid     <= nc_valid;
            tc_iretired  <= nc_iretired;
            tc_exception <= nc_exception;
            tc_interrupt <= nc_interrupt;
            tc_branch    <= nc_branch;
            tc_updiscon  <= nc_updiscon;
            lc_valid     <= tc_valid;
            lc_exception <= tc_exception;
            lc_interrupt <= tc_interrupt;
            lc_updiscon  <= tc_updiscon;
            // sticky, first retirement switches tracing on
            if (iretired_i) begin
                trace_active <= 1'b1;
            end
            if (tc_qualified) begin
                qualified_seen <= 1'b1;
            end
        end
    end

    // payload of the three stages
    always_ff @(posedge clk_i) begin
        nc_cause <= cause;
        nc_tval  <= tval;
        nc_priv  <= priv_lvl_i;
        nc_inst  <= inst_data_i;
        nc_iaddr <= pc_i;
        tc_cause <= nc_cause;
        tc_tval  <= nc_tval;
        tc_priv  <= nc_priv;
        tc_iaddr <= nc_iaddr;
        lc_cause <= tc_cause;
        lc_tval  <= tc_tval;
    end

    assign tc_qualified       = tc_valid && tc_iretired && trace_active;
    assign tc_first_qualified = tc_qualified && !qualified_seen;

    // no compressed instructions, fall-through is always +4
    assign tc_taken = (nc_iaddr != tc_iaddr + addr_t'(4));

    trdb_itype_detector i_trdb_itype_detector (
        .nc_inst_data_i(nc_inst),
        .nc_branch_o   (nc_branch),
        .nc_updiscon_o (nc_updiscon)
    );

    trdb_branch_map i_trdb_branch_map (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .valid_i       (tc_qualified && tc_branch),
        .branch_taken_i(tc_taken),
        .flush_i       (map_flush),
        .map_o         (branch_map),
        .branches_o    (branch_count),
        .is_full_o     (map_full)
    );

    trdb_resync_counter i_trdb_resync_counter (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .packet_emitted_i(map_flush),
        .resync_rst_i    (resync_rst),
        .resync_req_o    (resync_req)
    );

    // trap seen one instruction back, gated by lc valid
    trdb_priority i_trdb_priority (
        .tc_qualified_i      (tc_qualified),
        .tc_first_qualified_i(tc_first_qualified),
        .lc_exception_i      (lc_valid && (lc_exception || lc_interrupt)),
        .lc_updiscon_i       (lc_valid && lc_updiscon),
        .resync_req_i        (resync_req),
        .tc_branch_i         (tc_branch),
        .branches_i          (branch_count),
        .map_full_i          (map_full),
        .packet_type_o       (tc_packet_type),
        .flush_o             (map_flush),
        .resync_rst_o        (resync_rst)
    );

    trdb_packet_emitter i_trdb_packet_emitter (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .packet_type_i    (tc_packet_type),
        .tc_priv_i        (tc_priv),
        .tc_iaddr_i       (tc_iaddr),
        .lc_cause_i       (lc_cause),
        .lc_tval_i        (lc_tval),
        .lc_interrupt_i   (lc_interrupt),
        .tc_branch_i      (tc_branch),
        .tc_branch_taken_i(tc_taken),
        .branches_i       (branch_count),
        .map_i            (branch_map),
        .packet_valid_o   (packet_valid_o),
        .packet_type_o    (packet_type_o),
        .packet_length_o  (packet_length_o),
        .packet_payload_o (packet_payload_o)
    );

endmodule

//--- hdl/trdb_branch_map.sv
// branch map
// collects conditional branch outcomes until a packet flushes them

module trdb_branch_map import trdb_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          valid_i,
    input  logic          branch_taken_i,
    input  logic          flush_i,
    output branch_map_t   map_o,
    output branch_count_t branches_o,
    output logic          is_full_o
);

    branch_map_t   map_q;
    branch_count_t count_q;
    branch_map_t   new_bit;

    // oldest outcome sits in bit 0
    // a set bit means not taken, as in the e-trace map
    assign new_bit = branch_map_t'(!branch_taken_i) << count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // an outcome arriving now already went into the packet
            map_q   <= '0;
            count_q <= '0;
        end else if (valid_i) begin
            map_q   <= map_q | new_bit;
            count_q <= count_q + branch_count_t'(1);
        end
    end

    assign map_o      = map_q;
    assign branches_o = count_q;
    assign is_full_o  = (count_q == branch_count_t'(BRANCH_MAP_LEN));

endmodule

//--- hdl/trdb_itype_detector.sv
// instruction type detector
// flags conditional branches and uninferable jumps in the nc word

module trdb_itype_detector import trdb_pkg::*; (
    input  inst_t nc_inst_data_i,
    output logic  nc_branch_o,
    output logic  nc_updiscon_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    // standard rv32 field positions
    assign opcode = nc_inst_data_i[6:0];
    assign funct3 = nc_inst_data_i[14:12];

    always_comb begin
        nc_branch_o   = 1'b0;
        nc_updiscon_o = 1'b0;
        case (opcode)
            // beq, bne, blt, bge, bltu, bgeu
            OPCODE_BRANCH: begin
                nc_branch_o = (funct3 != 3'b010) && (funct3 != 3'b011);
            end
            // jalr target is register based, not inferable
            OPCODE_JALR: begin
                nc_updiscon_o = (funct3 == 3'b000);
            end
            // jal and the rest follow from the binary
            default: begin
                nc_branch_o   = 1'b0;
                nc_updiscon_o = 1'b0;
            end
        endcase
    end

endmodule

//--- hdl/trdb_packet_emitter.sv
// packet emitter
// packs the fields of the chosen format and registers payload and length

module trdb_packet_emitter import trdb_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  packet_type_e  packet_type_i,
    input  priv_lvl_e     tc_priv_i,
    input  addr_t         tc_iaddr_i,
    input  cause_t        lc_cause_i,
    input  addr_t         lc_tval_i,
    input  logic          lc_interrupt_i,
    input  logic          tc_branch_i,
    input  logic          tc_branch_taken_i,
    input  branch_count_t branches_i,
    input  branch_map_t   map_i,
    output logic          packet_valid_o,
    output packet_type_e  packet_type_o,
    output length_t       packet_length_o,
    output payload_t      packet_payload_o
);

    branch_map_t   map_all;
    branch_count_t count_all;
    payload_t      payload_d;
    length_t       length_d;

    // fold the tc outcome in, same bit order as the map
    always_comb begin
        map_all   = map_i;
        count_all = branches_i;
        if (tc_branch_i) begin
            map_all   = map_i | (branch_map_t'(!tc_branch_taken_i) << branches_i);
            count_all = branches_i + branch_count_t'(1);
        end
    end

    // fields packed from bit 0 up, rest left zero
    always_comb begin
        payload_d = '0;
        length_d  = '0;
        case (packet_type_i)
            F_SYNC_START: begin
                payload_d = payload_t'({tc_iaddr_i, tc_priv_i});
                length_d  = length_t'(5);
            end
            F_SYNC_TRAP: begin
                payload_d = payload_t'({lc_tval_i, tc_iaddr_i, lc_cause_i,
                                        lc_interrupt_i, tc_priv_i});
                length_d  = length_t'(9);
            end
            F_BRANCH_FULL: begin
                payload_d = payload_t'({map_all, count_all});
                length_d  = length_t'(5);
            end
            F_BRANCH_ADDR: begin
                payload_d = payload_t'({tc_iaddr_i, map_all, count_all});
                length_d  = length_t'(9);
            end
            F_ADDR_ONLY: begin
                // full address, no delta compression
                payload_d = payload_t'(tc_iaddr_i);
                length_d  = length_t'(4);
            end
            default: begin
                payload_d = '0;
                length_d  = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o   <= 1'b0;
            packet_type_o    <= NONE;
            packet_length_o  <= '0;
            packet_payload_o <= '0;
        end else begin
            // one cycle strobe, no back-pressure
            packet_valid_o   <= (packet_type_i != NONE);
            packet_type_o    <= packet_type_i;
            packet_length_o  <= length_d;
            packet_payload_o <= payload_d;
        end
    end

endmodule

//--- hdl/trdb_pkg.sv
// trace encoder package
// shared widths, vector types, privilege and packet-format encodings

package trdb_pkg;

    // core interface widths
    localparam int XLEN             = 32;
    localparam int INST_LEN         = 32;
    localparam int CAUSE_LEN        = 5;

    // branch map, one bit per conditional branch outcome
    localparam int BRANCH_MAP_LEN   = 31;
    localparam int BRANCH_COUNT_LEN = 5;

    // packet geometry
    localparam int PAYLOAD_LEN      = 96;
    localparam int P_LEN            = 4;

    // packets between forced sync packets
    localparam int RESYNC_MAX       = 8;
    localparam int RESYNC_CNT_LEN   = $clog2(RESYNC_MAX + 1);

    // rv32 major opcodes of interest
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;

    typedef logic [XLEN-1:0]             addr_t;
    typedef logic [INST_LEN-1:0]         inst_t;
    typedef logic [CAUSE_LEN-1:0]        cause_t;
    typedef logic [BRANCH_MAP_LEN-1:0]   branch_map_t;
    typedef logic [BRANCH_COUNT_LEN-1:0] branch_count_t;
    typedef logic [PAYLOAD_LEN-1:0]      payload_t;
    typedef logic [P_LEN-1:0]            length_t;

    // privilege levels, encoding as in mstatus.mpp
    typedef enum logic [1:0] {
        U = 2'b00,
        S = 2'b01,
        M = 2'b11
    } priv_lvl_e;

    // upper two bits hold the format, lower two the subformat
    typedef enum logic [3:0] {
        NONE          = 4'b0000,
        F_BRANCH_FULL = 4'b0100,
        F_BRANCH_ADDR = 4'b0101,
        F_ADDR_ONLY   = 4'b1000,
        F_SYNC_START  = 4'b1100,
        F_SYNC_TRAP   = 4'b1101
    } packet_type_e;

endpackage

//--- hdl/trdb_priority.sv
// packet priority logic
// chooses the packet format for the tc instruction, first rule wins

module trdb_priority import trdb_pkg::*; (
    input  logic          tc_qualified_i,
    input  logic          tc_first_qualified_i,
    input  logic          lc_exception_i,
    input  logic          lc_updiscon_i,
    input  logic          resync_req_i,
    input  logic          tc_branch_i,
    input  branch_count_t branches_i,
    input  logic          map_full_i,
    output packet_type_e  packet_type_o,
    output logic          flush_o,
    output logic          resync_rst_o
);

    logic has_branches;
    logic full_with_tc;

    // count seen with the tc outcome already added
    assign has_branches = tc_branch_i || (branches_i != '0);

    // tc branch fills the last free slot
    assign full_with_tc = map_full_i ||
                          (tc_branch_i && (branches_i == branch_count_t'(BRANCH_MAP_LEN - 1)));

    always_comb begin
        packet_type_o = NONE;
        if (tc_qualified_i) begin
            if (tc_first_qualified_i) begin
                // tracing just started
                packet_type_o = F_SYNC_START;
            end else if (lc_exception_i) begin
                // tc is the first handler instruction
                packet_type_o = F_SYNC_TRAP;
            end else if (resync_req_i) begin
                packet_type_o = F_SYNC_START;
            end else if (lc_updiscon_i) begin
                // tc is the target of an uninferable jump
                if (has_branches) begin
                    packet_type_o = F_BRANCH_ADDR;
                end else begin
                    packet_type_o = F_ADDR_ONLY;
                end
            end else if (full_with_tc) begin
                packet_type_o = F_BRANCH_FULL;
            end else begin
                packet_type_o = NONE;
            end
        end
    end

    // every packet empties the map
    assign flush_o = (packet_type_o != NONE);

    // sync packets restart the resync window
    assign resync_rst_o = (packet_type_o == F_SYNC_START) ||
                          (packet_type_o == F_SYNC_TRAP);

endmodule

//--- hdl/trdb_resync_counter.sv
// resync counter
// requests a sync packet after RESYNC_MAX packets without one

module trdb_resync_counter import trdb_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic packet_emitted_i,
    input  logic resync_rst_i,
    output logic resync_req_o
);

    logic [RESYNC_CNT_LEN-1:0] count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (resync_rst_i) begin
            // any sync packet restarts the window
            count_q <= '0;
        end else if (packet_emitted_i && !resync_req_o) begin
            count_q <= count_q + RESYNC_CNT_LEN'(1);
        end
    end

    // saturates, so the request holds until a sync
    assign resync_req_o = (count_q == RESYNC_CNT_LEN'(RESYNC_MAX));

endmodule

//--- list.f
hdl/trdb_pkg.sv
hdl/trdb_itype_detector.sv
hdl/trdb_branch_map.sv
hdl/trdb_resync_counter.sv
hdl/trdb_priority.sv
hdl/trdb_packet_emitter.sv
hdl/trace_debugger.sv
test/tb_trace_debugger.sv

//--- test/tb_trace_debugger.sv
// testbench for the trace encoder top level
// replays per-cycle stimulus from a case file and checks the packet outputs

module tb_trace_debugger import trdb_pkg::*; ();

    localparam int MAX_CASES    = 256;
    localparam int RESET_CYCLES = 3;
    localparam int SPARE_CYCLES = 20;

    logic         clk_i;
    logic         rst_ni;
    logic         inst_valid_i;
    logic         iretired_i;
    logic         exception_i;
    logic         interrupt_i;
    priv_lvl_e    priv_lvl_i;
    cause_t       ucause_i;
    cause_t       scause_i;
    cause_t       mcause_i;
    addr_t        utval_i;
    addr_t        stval_i;
    addr_t        mtval_i;
    inst_t        inst_data_i;
    addr_t        pc_i;
    logic         packet_valid_o;
    packet_type_e packet_type_o;
    length_t      packet_length_o;
    payload_t     packet_payload_o;

    // one entry per cycle, inputs then expected outputs
    logic [3:0]   ctrl_mem [MAX_CASES];
    logic [1:0]   priv_mem [MAX_CASES];
    cause_t       ucause_mem [MAX_CASES];
    cause_t       scause_mem [MAX_CASES];
    cause_t       mcause_mem [MAX_CASES];
    addr_t        utval_mem [MAX_CASES];
    addr_t        stval_mem [MAX_CASES];
    addr_t        mtval_mem [MAX_CASES];
    inst_t        inst_mem [MAX_CASES];
    addr_t        pc_mem [MAX_CASES];
    logic         exp_valid_mem [MAX_CASES];
    logic [3:0]   exp_type_mem [MAX_CASES];
    length_t      exp_length_mem [MAX_CASES];
    payload_t     exp_payload_mem [MAX_CASES];

    int           num_cases = 0;
    int           cycles = 0;
    int           cycle_limit = MAX_CASES + SPARE_CYCLES + RESET_CYCLES;

    trace_debugger DUT (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .inst_valid_i    (inst_valid_i),
        .iretired_i      (iretired_i),
        .exception_i     (exception_i),
        .interrupt_i     (interrupt_i),
        .priv_lvl_i      (priv_lvl_i),
        .ucause_i        (ucause_i),
        .scause_i        (scause_i),
        .mcause_i        (mcause_i),
        .utval_i         (utval_i),
        .stval_i         (stval_i),
        .mtval_i         (mtval_i),
        .inst_data_i     (inst_data_i),
        .pc_i            (pc_i),
        .packet_valid_o  (packet_valid_o),
        .packet_type_o   (packet_type_o),
        .packet_length_o (packet_length_o),
        .packet_payload_o(packet_payload_o)
    );

    // period 8
    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    task automatic abort_run();
        $display("Errors found");
        $fatal(1);
    endtask

    // guard against a stuck run
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: packet_valid_o is %0b, expected %0b", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_type(input packet_type_e got, input packet_type_e exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: packet_type_o is %0h, expected %0h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic verify_length(input length_t got, input length_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: packet_length_o is %0d, expected %0d", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic match_payload(input payload_t got, input payload_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: packet_payload_o is %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    // lines starting with # are comments
    task automatic load_cases();
        int    fd;
        int    n;
        string line;
        logic [3:0] c;
        logic [1:0] p;
        cause_t     uc, sc, mc;
        addr_t      ut, st, mt, pc;
        inst_t      inst;
        logic       ev;
        logic [3:0] et;
        length_t    el;
        payload_t   ep;
        fd = $fopen("test/trace_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open test/trace_cases.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        c, p, uc, sc, mc, ut, st, mt, inst, pc, ev, et, el, ep);
            if (n != 14 || num_cases >= MAX_CASES) begin
                $display("case file line %0d could not be read", num_cases);
                abort_run();
            end
            ctrl_mem[num_cases]        = c;
            priv_mem[num_cases]        = p;
            ucause_mem[num_cases]      = uc;
            scause_mem[num_cases]      = sc;
            mcause_mem[num_cases]      = mc;
            utval_mem[num_cases]       = ut;
            stval_mem[num_cases]       = st;
            mtval_mem[num_cases]       = mt;
            inst_mem[num_cases]        = inst;
            pc_mem[num_cases]          = pc;
            exp_valid_mem[num_cases]   = ev;
            exp_type_mem[num_cases]    = et;
            exp_length_mem[num_cases]  = el;
            exp_payload_mem[num_cases] = ep;
            num_cases++;
        end
        $fclose(fd);
    endtask

    // ctrl nibble is valid, retired, exception, interrupt from msb down
    task automatic apply_inputs(input int k);
        inst_valid_i = ctrl_mem[k][3];
        iretired_i   = ctrl_mem[k][2];
        exception_i  = ctrl_mem[k][1];
        interrupt_i  = ctrl_mem[k][0];
        priv_lvl_i   = priv_lvl_e'(priv_mem[k]);
        ucause_i     = ucause_mem[k];
        scause_i     = scause_mem[k];
        mcause_i     = mcause_mem[k];
        utval_i      = utval_mem[k];
        stval_i      = stval_mem[k];
        mtval_i      = mtval_mem[k];
        inst_data_i  = inst_mem[k];
        pc_i         = pc_mem[k];
    endtask

    initial begin
        rst_ni       = 1'b0;
        inst_valid_i = 1'b0;
        iretired_i   = 1'b0;
        exception_i  = 1'b0;
        interrupt_i  = 1'b0;
        priv_lvl_i   = M;
        ucause_i     = '0;
        scause_i     = '0;
        mcause_i     = '0;
        utval_i      = '0;
        stval_i      = '0;
        mtval_i      = '0;
        inst_data_i  = '0;
        pc_i         = '0;
        load_cases();
        cycle_limit = num_cases + SPARE_CYCLES + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        for (int k = 0; k < num_cases; k++) begin
            @(posedge clk_i);
            #1 apply_inputs(k);
            // outputs settled, next edge is 1 unit away
            #6;
            check_valid(packet_valid_o, exp_valid_mem[k]);
            compare_type(packet_type_o, packet_type_e'(exp_type_mem[k]));
            verify_length(packet_length_o, exp_length_mem[k]);
            match_payload(packet_payload_o, exp_payload_mem[k]);
        end
        $display("No errors");
        $finish;
    end

endmodule

//--- test/trace_cases.txt
# ctl(valid,retired,exc,irq) priv ucause scause mcause utval stval mtval inst pc
# then expected: valid type length payload, packet of line k shows at line k+3
0 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0
c 3 0 0 0 0 0 0 00000013 00000100 0 0 0 0
c 3 0 0 0 0 0 0 00000013 00000104 0 0 0 0
a 3 01 03 02 11111111 22222222 deadbeef 00000013 00000108 0 0 0 0
c 3 0 0 0 0 0 0 00000013 00000200 1 c 5 403
a 1 01 0d 02 11111111 22222222 33333333 00000013 00000204 0 0 0 0
c 1 0 0 0 0 0 0 00000013 00000300 0 0 0 0
9 0 07 01 02 44444444 22222222 33333333 00000013 00000304 1 d 9 000000deadbeef0000020013
c 3 0 0 0 0 0 0 00000013 00000400 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000404 1 d 9 000000222222220000030069
c 3 0 0 0 0 0 0 00000063 00000408 0 0 0 0
c 3 0 0 0 0 0 0 00000013 00000500 1 d 9 00000044444444000004003f
c 3 0 0 0 0 0 0 00000063 00000504 0 0 0 0
c 3 0 0 0 0 0 0 00000067 00000508 0 0 0 0
c 3 0 0 0 0 0 0 00000013 00000600 0 0 0 0
c 3 0 0 0 0 0 0 00000067 00000604 0 0 0 0
c 3 0 0 0 0 0 0 00000013 00000700 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000800 1 5 9 0000000000006000000000a3
c 3 0 0 0 0 0 0 00000063 00000804 0 0 0 0
c 3 0 0 0 0 0 0 00000063 0000080c 1 8 4 700
c 3 0 0 0 0 0 0 00000063 00000810 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000814 0 0 0 0
c 3 0 0 0 0 0 0 00000063 0000081c 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000820 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000824 0 0 0 0
c 3 0 0 0 0 0 0 00000063 0000082c 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000830 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000834 0 0 0 0
c 3 0 0 0 0 0 0 00000063 0000083c 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000840 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000844 0 0 0 0
c 3 0 0 0 0 0 0 00000063 0000084c 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000850 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000854 0 0 0 0
c 3 0 0 0 0 0 0 00000063 0000085c 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000860 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000864 0 0 0 0
c 3 0 0 0 0 0 0 00000063 0000086c 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000870 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000874 0 0 0 0
c 3 0 0 0 0 0 0 00000063 0000087c 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000880 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000884 0 0 0 0
c 3 0 0 0 0 0 0 00000063 0000088c 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000890 0 0 0 0
c 3 0 0 0 0 0 0 00000063 00000894 0 0 0 0
c 3 0 0 0 0 0 0 00000063 0000089c 0 0 0 0
c 3 0 0 0 0 0 0 00000063 000008a0 0 0 0 0
c 3 0 0 0 0 0 0 00000063 000008a4 0 0 0 0
c 3 0 0 0 0 0 0 00000067 000008b0 0 0 0 0
c 3 0 0 0 0 0 0 00000067 00000900 1 4 5 000000000000000db6db6dbf
c 3 0 0 0 0 0 0 00000067 00000a00 0 0 0 0
c 3 0 0 0 0 0 0 00000067 00000b00 0 0 0 0
c 3 0 0 0 0 0 0 00000067 00000c00 1 5 9 000000000000900000000001
c 3 0 0 0 0 0 0 00000067 00000d00 1 8 4 a00
c 3 0 0 0 0 0 0 00000013 00000e00 1 8 4 b00
0 3 0 0 0 0 0 0 00000000 00000000 1 8 4 c00
0 3 0 0 0 0 0 0 00000000 00000000 1 8 4 d00
0 3 0 0 0 0 0 0 00000000 00000000 1 c 5 3803
0 3 0 0 0 0 0 0 00000000 00000000 0 0 0 0
